//--- jtagTapPkg.sv
package jtagTapPkg;

  // Width of the TAP state register
  localparam int tapStateBits = 4;

  // TMS-high edges that always reach testLogicReset
  localparam int tapResetEdges = 5;

  // Sixteen TAP controller states, DR branch first and then the IR branch
  typedef enum logic [tapStateBits-1:0] {
    testLogicReset = 4'd0,
    runTestIdle    = 4'd1,
    selectDrScan   = 4'd2,
    captureDr      = 4'd3,
    shiftDr        = 4'd4,
    exit1Dr        = 4'd5,
    pauseDr        = 4'd6,
    exit2Dr        = 4'd7,
    updateDr       = 4'd8,
    selectIrScan   = 4'd9,
    captureIr      = 4'd10,
    shiftIr        = 4'd11,
    exit1Ir        = 4'd12,
    pauseIr        = 4'd13,
    exit2Ir        = 4'd14,
    updateIr       = 4'd15
  } tapStateT;

  // Control strobes decoded from the TAP state
  // Capture, shift and update act as enables at the next rising edge of TCK
  typedef struct packed {
    logic testReset;
    logic selectIr;
    logic captureDr;
    logic shiftDr;
    logic updateDr;
    logic captureIr;
    logic shiftIr;
    logic updateIr;
    logic shiftActive;
  } tapCtrlT;

endpackage

//--- jtagInstrPkg.sv
package jtagInstrPkg;

  // Register widths
  localparam int irWidth     = 4;
  localparam int idcodeWidth = 32;
  localparam int userWidth   = 32;

  // Loaded into the IR shift stage on captureIr
  localparam logic [irWidth-1:0] irCapturePattern = 4'b0101;

  // Device identification, bit 0 set as 1149.1 requires
  localparam logic [idcodeWidth-1:0] idcodeValue = 32'h1A5C_0F3D;

  // Instruction codes
  localparam logic [irWidth-1:0] instIdcode = 4'h1;
  localparam logic [irWidth-1:0] instUser   = 4'h8;
  localparam logic [irWidth-1:0] instBypass = 4'hF;

  // Data register placed between TDI and TDO
  typedef enum logic [1:0] {
    selBypass = 2'd0,
    selIdcode = 2'd1,
    selUser   = 2'd2
  } drSelT;

endpackage

//--- tapController.sv
`timescale 1ns/10ps

module tapController (
  input  logic                TCK,
  input  logic                rstN,
  input  logic                tms,
  output jtagTapPkg::tapCtrlT ctrl
);

  import jtagTapPkg::*;

  tapStateT state;
  tapStateT nextState;

  always_ff @(posedge TCK or negedge rstN) begin
    if (!rstN) begin
      state <= testLogicReset;
    end else begin
      state <= nextState;
    end
  end

  // IEEE 1149.1 state diagram
  always_comb begin
    nextState = state;
    case (state)
      testLogicReset: begin
        nextState = tms ? testLogicReset : runTestIdle;
      end
      runTestIdle: begin
        nextState = tms ? selectDrScan : runTestIdle;
      end
      selectDrScan: begin
        nextState = tms ? selectIrScan : captureDr;
      end
      captureDr: begin
        nextState = tms ? exit1Dr : shiftDr;
      end
      shiftDr: begin
        nextState = tms ? exit1Dr : shiftDr;
      end
      exit1Dr: begin
        nextState = tms ? updateDr : pauseDr;
      end
      pauseDr: begin
        nextState = tms ? exit2Dr : pauseDr;
      end
      exit2Dr: begin
        nextState = tms ? updateDr : shiftDr;
      end
      updateDr: begin
        nextState = tms ? selectDrScan : runTestIdle;
      end
      selectIrScan: begin
        nextState = tms ? testLogicReset : captureIr;
      end
      captureIr: begin
        nextState = tms ? exit1Ir : shiftIr;
      end
      shiftIr: begin
        nextState = tms ? exit1Ir : shiftIr;
      end
      exit1Ir: begin
        nextState = tms ? updateIr : pauseIr;
      end
      pauseIr: begin
        nextState = tms ? exit2Ir : pauseIr;
      end
      exit2Ir: begin
        nextState = tms ? updateIr : shiftIr;
      end
      updateIr: begin
        nextState = tms ? selectDrScan : runTestIdle;
      end
      default: begin
        nextState = testLogicReset;
      end
    endcase
  end

  // Strobes are plain decodes of the current state
  always_comb begin
    ctrl.testReset   = (state == testLogicReset);
    ctrl.captureDr   = (state == captureDr);
    ctrl.shiftDr     = (state == shiftDr);
    ctrl.updateDr    = (state == updateDr);
    ctrl.captureIr   = (state == captureIr);
    ctrl.shiftIr     = (state == shiftIr);
    ctrl.updateIr    = (state == updateIr);
    ctrl.shiftActive = (state == shiftDr) || (state == shiftIr);
    // IR side of the TDO mux, idle states included
    ctrl.selectIr = state inside {testLogicReset, runTestIdle, captureIr, shiftIr,
                                  exit1Ir, pauseIr, exit2Ir, updateIr};
  end

  // State register never goes unknown once out of reset
  stateKnown: assert property (
    @(posedge TCK) disable iff (!rstN)
    !$isunknown(state)
  ) else $error("TAP state outside the encoding");

  // Five TMS-high edges reach testLogicReset from anywhere
  tmsResetReach: assert property (
    @(posedge TCK) disable iff (!rstN)
    tms [*tapResetEdges] |=> (state == testLogicReset)
  ) else $error("TAP did not reach testLogicReset after TMS-high edges");

endmodule

//--- instructionRegister.sv
`timescale 1ns/10ps

module instructionRegister (
  input  logic                TCK,
  input  logic                rstN,
  input  jtagTapPkg::tapCtrlT ctrl,
  input  logic                tdi,
  output logic                irTdo,
  output jtagInstrPkg::drSelT drSel
);

  import jtagInstrPkg::*;

  logic [irWidth-1:0] irShift;
  logic [irWidth-1:0] irActive;

  // Shift stage, TDI enters at the MSB
  always_ff @(posedge TCK) begin
    if (ctrl.captureIr) begin
      irShift <= irCapturePattern;
    end else if (ctrl.shiftIr) begin
      irShift <= {tdi, irShift[irWidth-1:1]};
    end
  end

  assign irTdo = irShift[0];

  // Update latch holding the active instruction
  always_ff @(posedge TCK or negedge rstN) begin
    if (!rstN) begin
      irActive <= instIdcode;
    end else if (ctrl.testReset) begin
      irActive <= instIdcode;
    end else if (ctrl.updateIr) begin
      irActive <= irShift;
    end
  end

  // Unknown codes fall back to bypass
  always_comb begin
    case (irActive)
      instIdcode: drSel = selIdcode;
      instUser:   drSel = selUser;
      instBypass: drSel = selBypass;
      default:    drSel = selBypass;
    endcase
  end

  // Controller never asks for capture and shift on the same edge
  irCaptureShiftExcl: assert property (
    @(posedge TCK) disable iff (!rstN)
    !(ctrl.captureIr && ctrl.shiftIr)
  ) else $error("IR capture and shift enabled together");

endmodule

//--- dataRegisters.sv
`timescale 1ns/10ps

module dataRegisters (
  input  logic                             TCK,
  input  logic                             rstN,
  input  jtagTapPkg::tapCtrlT              ctrl,
  input  jtagInstrPkg::drSelT              drSel,
  input  logic                             tdi,
  input  logic [jtagInstrPkg::userWidth-1:0] userIn,
  output logic                             drTdo,
  output logic [jtagInstrPkg::userWidth-1:0] userOut,
  output logic                             userUpdate
);

  import jtagInstrPkg::*;

  logic                   bypassReg;
  logic [idcodeWidth-1:0] idShift;
  logic [userWidth-1:0]   userShift;

  logic captureBypass;
  logic captureIdcode;
  logic captureUser;
  logic shiftBypass;
  logic shiftIdcode;
  logic shiftUser;

  // Only the selected register sees capture and shift
  assign captureBypass = ctrl.captureDr && (drSel == selBypass);
  assign captureIdcode = ctrl.captureDr && (drSel == selIdcode);
  assign captureUser   = ctrl.captureDr && (drSel == selUser);
  assign shiftBypass   = ctrl.shiftDr && (drSel == selBypass);
  assign shiftIdcode   = ctrl.shiftDr && (drSel == selIdcode);
  assign shiftUser     = ctrl.shiftDr && (drSel == selUser);

  // Bypass captures 0 so the first bit out is known
  always_ff @(posedge TCK) begin
    if (captureBypass) begin
      bypassReg <= 1'b0;
    end else if (shiftBypass) begin
      bypassReg <= tdi;
    end
  end

  always_ff @(posedge TCK) begin
    if (captureIdcode) begin
      idShift <= idcodeValue;
    end else if (shiftIdcode) begin
      idShift <= {tdi, idShift[idcodeWidth-1:1]};
    end
  end

  // User shift stage takes the core word at capture
  always_ff @(posedge TCK) begin
    if (captureUser) begin
      userShift <= userIn;
    end else if (shiftUser) begin
      userShift <= {tdi, userShift[userWidth-1:1]};
    end
  end

  always_comb begin
    case (drSel)
      selIdcode: drTdo = idShift[0];
      selUser:   drTdo = userShift[0];
      default:   drTdo = bypassReg;
    endcase
  end

  // Holding register toward the core, strobed on the edge that leaves updateDr
  always_ff @(posedge TCK or negedge rstN) begin
    if (!rstN) begin
      userOut    <= '0;
      userUpdate <= 1'b0;
    end else begin
      userUpdate <= ctrl.updateDr && (drSel == selUser);
      if (ctrl.updateDr && (drSel == selUser)) begin
        userOut <= userShift;
      end
    end
  end

  // One pulse per pass through updateDr
  userUpdateSingle: assert property (
    @(posedge TCK) disable iff (!rstN)
    userUpdate |=> !userUpdate
  ) else $error("userUpdate high on two consecutive cycles");

endmodule

//--- tdoOutputStage.sv
`timescale 1ns/10ps

module tdoOutputStage (
  input  logic                TCK,
  input  logic                rstN,
  input  jtagTapPkg::tapCtrlT ctrl,
  input  logic                irTdo,
  input  logic                drTdo,
  output logic                tdo,
  output logic                tdoEnable
);

  logic tdoNext;

  // IR chain in the IR branch, DR chain otherwise
  assign tdoNext = ctrl.selectIr ? irTdo : drTdo;

  // Falling edge retiming keeps TDO stable around the next rising edge
  always_ff @(negedge TCK or negedge rstN) begin
    if (!rstN) begin
      tdo       <= 1'b0;
      tdoEnable <= 1'b0;
    end else begin
      tdoEnable <= ctrl.shiftActive;
      if (ctrl.shiftActive) begin
        tdo <= tdoNext;
      end else begin
        // Quiet low between scans
        tdo <= 1'b0;
      end
    end
  end

endmodule

//--- jtagTap.sv
`timescale 1ns/10ps

module jtagTap (
  input  logic                             TCK,
  input  logic                             rstN,
  input  logic                             tms,
  input  logic                             tdi,
  input  logic [jtagInstrPkg::userWidth-1:0] userIn,
  output logic                             tdo,
  output logic                             tdoEnable,
  output logic [jtagInstrPkg::userWidth-1:0] userOut,
  output logic                             userUpdate
);

  import jtagTapPkg::*;
  import jtagInstrPkg::*;

  tapCtrlT ctrl;
  drSelT   drSel;
  logic    irTdo;
  logic    drTdo;

  // Stage 1, state machine and strobes
  tapController tapController0 (
    .TCK  (TCK),
    .rstN (rstN),
    .tms  (tms),
    .ctrl (ctrl)
  );

  // Stage 2, shift registers
  instructionRegister instructionRegister0 (
    .TCK   (TCK),
    .rstN  (rstN),
    .ctrl  (ctrl),
    .tdi   (tdi),
    .irTdo (irTdo),
    .drSel (drSel)
  );

  dataRegisters dataRegisters0 (
    .TCK        (TCK),
    .rstN       (rstN),
    .ctrl       (ctrl),
    .drSel      (drSel),
    .tdi        (tdi),
    .userIn     (userIn),
    .drTdo      (drTdo),
    .userOut    (userOut),
    .userUpdate (userUpdate)
  );

  // Stage 3, falling edge output
  tdoOutputStage tdoOutputStage0 (
    .TCK       (TCK),
    .rstN      (rstN),
    .ctrl      (ctrl),
    .irTdo     (irTdo),
    .drTdo     (drTdo),
    .tdo       (tdo),
    .tdoEnable (tdoEnable)
  );

endmodule

//--- tbJtagTap.sv
`timescale 1ns/10ps

module tbJtagTap;

  import jtagTapPkg::*;
  import jtagInstrPkg::*;

  // Well above the length of the whole test sequence
  localparam int maxCycles = 4000;

  logic                 TCK;
  logic                 rstN;
  logic                 tms;
  logic                 tdi;
  logic [userWidth-1:0] userIn;
  logic                 tdo;
  logic                 tdoEnable;
  logic [userWidth-1:0] userOut;
  logic                 userUpdate;

  // Reference TAP model, state as seen just before the next rising edge
  tapStateT             refState;
  logic [irWidth-1:0]   refIrShift;
  logic [irWidth-1:0]   refIrActive;
  logic                 refBypass;
  logic [userWidth-1:0] refIdShift;
  logic [userWidth-1:0] refUserShift;
  logic [userWidth-1:0] refUserOut;
  logic                 refUpdatePending;

  // Expected outputs for the current cycle
  logic                 checkArmed;
  logic                 expTdo;
  logic                 expEnable;
  logic                 expUpdate;
  logic [userWidth-1:0] expUserOut;
  logic [userWidth-1:0] nextUserIn;
  string                testName;
  int                   updateCount;
  int                   cycleCount;

  jtagTap dut0 (
    .TCK        (TCK),
    .rstN       (rstN),
    .tms        (tms),
    .tdi        (tdi),
    .userIn     (userIn),
    .tdo        (tdo),
    .tdoEnable  (tdoEnable),
    .userOut    (userOut),
    .userUpdate (userUpdate)
  );

  initial TCK = 1'b0;
  always #5 TCK = ~TCK;

  task automatic failRun(input string msg);
    $display("%s", msg);
    $display("Simulation finished: FAIL");
    $fatal(1);
  endtask

  task automatic checkValue(input string name, input logic [31:0] expected,
                            input logic [31:0] actual);
    assert (actual === expected)
    else failRun($sformatf("FAILED %s: expected %08h, actual %08h", name, expected, actual));
  endtask

  // IEEE 1149.1 state diagram
  function automatic tapStateT nextTapState(tapStateT s, logic tmsVal);
    case (s)
      testLogicReset: return tmsVal ? testLogicReset : runTestIdle;
      runTestIdle:    return tmsVal ? selectDrScan : runTestIdle;
      selectDrScan:   return tmsVal ? selectIrScan : captureDr;
      captureDr:      return tmsVal ? exit1Dr : shiftDr;
      shiftDr:        return tmsVal ? exit1Dr : shiftDr;
      exit1Dr:        return tmsVal ? updateDr : pauseDr;
      pauseDr:        return tmsVal ? exit2Dr : pauseDr;
      exit2Dr:        return tmsVal ? updateDr : shiftDr;
      updateDr:       return tmsVal ? selectDrScan : runTestIdle;
      selectIrScan:   return tmsVal ? testLogicReset : captureIr;
      captureIr:      return tmsVal ? exit1Ir : shiftIr;
      shiftIr:        return tmsVal ? exit1Ir : shiftIr;
      exit1Ir:        return tmsVal ? updateIr : pauseIr;
      pauseIr:        return tmsVal ? exit2Ir : pauseIr;
      exit2Ir:        return tmsVal ? updateIr : shiftIr;
      default:        return tmsVal ? selectDrScan : runTestIdle;
    endcase
  endfunction

  // Unknown instructions select bypass
  function automatic drSelT decodeInstr(logic [irWidth-1:0] code);
    case (code)
      instIdcode: return selIdcode;
      instUser:   return selUser;
      default:    return selBypass;
    endcase
  endfunction

  // TDO is only driven while shifting and stays low otherwise
  function automatic logic expectedTdoBit(tapStateT s, logic irBit, logic drBit);
    if (s == shiftIr) begin
      return irBit;
    end
    if (s == shiftDr) begin
      return drBit;
    end
    return 1'b0;
  endfunction

  // What the rising edge does to the model registers
  task automatic advanceModel(input logic tmsVal, input logic tdiVal, input drSelT sel);
    case (refState)
      testLogicReset: refIrActive = instIdcode;
      captureIr:      refIrShift = irCapturePattern;
      shiftIr:        refIrShift = {tdiVal, refIrShift[irWidth-1:1]};
      updateIr:       refIrActive = refIrShift;
      captureDr: begin
        if (sel == selIdcode) begin
          refIdShift = idcodeValue;
        end else if (sel == selUser) begin
          refUserShift = userIn;
        end else begin
          refBypass = 1'b0;
        end
      end
      shiftDr: begin
        if (sel == selIdcode) begin
          refIdShift = {tdiVal, refIdShift[userWidth-1:1]};
        end else if (sel == selUser) begin
          refUserShift = {tdiVal, refUserShift[userWidth-1:1]};
        end else begin
          refBypass = tdiVal;
        end
      end
      default: ;
    endcase
    refUpdatePending = (refState == updateDr) && (sel == selUser);
    if (refUpdatePending) begin
      refUserOut = refUserShift;
    end
    refState = nextTapState(refState, tmsVal);
  endtask

  // One TCK cycle: drive on the falling edge, sample just before the rising edge
  task automatic step(input logic tmsVal, input logic tdiVal, output logic tdoSeen);
    drSelT sel;
    logic  drBit;
    @(negedge TCK);
    tms    = tmsVal;
    tdi    = tdiVal;
    userIn = nextUserIn;
    sel    = decodeInstr(refIrActive);
    if (sel == selIdcode) begin
      drBit = refIdShift[0];
    end else if (sel == selUser) begin
      drBit = refUserShift[0];
    end else begin
      drBit = refBypass;
    end
    expTdo     = expectedTdoBit(refState, refIrShift[0], drBit);
    expEnable  = (refState == shiftDr) || (refState == shiftIr);
    expUpdate  = refUpdatePending;
    expUserOut = refUserOut;
    checkArmed = 1'b1;
    #4;
    tdoSeen = tdo;
    advanceModel(tmsVal, tdiVal, sel);
  endtask

  // Starts and ends in runTestIdle
  task automatic scanIr(input logic [irWidth-1:0] code, output logic [irWidth-1:0] captured);
    logic b;
    int   i;
    step(1'b1, 1'b0, b);
    step(1'b1, 1'b0, b);
    step(1'b0, 1'b0, b);
    step(1'b0, 1'b0, b);
    for (i = 0; i < irWidth; i++) begin
      step(i == irWidth - 1, code[i], b);
      captured[i] = b;
    end
    step(1'b1, 1'b0, b);
    step(1'b0, 1'b0, b);
  endtask

  // Starts and ends in runTestIdle, with an optional pause after pauseAt bits
  task automatic scanDr(input int nBits, input logic [31:0] dataIn, input int pauseAt,
                        output logic [31:0] dataOut);
    logic b;
    int   i;
    dataOut = '0;
    step(1'b1, 1'b0, b);
    step(1'b0, 1'b0, b);
    step(1'b0, 1'b0, b);
    for (i = 0; i < nBits; i++) begin
      step((i == nBits - 1) || (i == pauseAt - 1), dataIn[i], b);
      dataOut[i] = b;
      if ((i == pauseAt - 1) && (i != nBits - 1)) begin
        // exit1Dr, pauseDr, pauseDr, exit2Dr, back to shiftDr
        step(1'b0, 1'b0, b);
        step(1'b0, 1'b0, b);
        step(1'b1, 1'b0, b);
        step(1'b0, 1'b0, b);
      end
    end
    step(1'b1, 1'b0, b);
    step(1'b0, 1'b0, b);
    // Cycle in which userUpdate may pulse
    step(1'b0, 1'b0, b);
  endtask

  // Per-cycle comparison with the reference model
  always @(negedge TCK) begin
    #3;
    if (checkArmed) begin
      assert (tdo === expTdo)
      else failRun($sformatf("FAILED %s tdo: expected %0b, actual %0b", testName, expTdo, tdo));
      assert (tdoEnable === expEnable)
      else failRun($sformatf("FAILED %s tdoEnable: expected %0b, actual %0b",
                             testName, expEnable, tdoEnable));
      assert (userUpdate === expUpdate)
      else failRun($sformatf("FAILED %s userUpdate: expected %0b, actual %0b",
                             testName, expUpdate, userUpdate));
      assert (userOut === expUserOut)
      else failRun($sformatf("FAILED %s userOut: expected %08h, actual %08h",
                             testName, expUserOut, userOut));
      if (userUpdate === 1'b1) begin
        updateCount++;
      end
    end
  end

  always @(posedge TCK) begin
    cycleCount++;
    if (cycleCount >= maxCycles) begin
      failRun($sformatf("Timeout: tests did not complete within %0d cycles", maxCycles));
    end
  end

  initial begin
    logic                 b;
    logic [31:0]          word;
    logic [31:0]          sent;
    logic [31:0]          userWord;
    logic [irWidth-1:0]   irOut;
    int                   pulsesBefore;
    int                   i;
    void'($urandom(32'ha5c2_dc5b));
    rstN             = 1'b0;
    tms              = 1'b1;
    tdi              = 1'b0;
    userIn           = '0;
    nextUserIn       = '0;
    checkArmed       = 1'b0;
    updateCount      = 0;
    cycleCount       = 0;
    testName         = "reset";
    refState         = testLogicReset;
    refIrActive      = instIdcode;
    refUserOut       = '0;
    refUpdatePending = 1'b0;
    repeat (16) @(negedge TCK);
    rstN = 1'b1;

    testName = "idcodeAfterReset";
    step(1'b0, 1'b0, b);
    scanDr(32, $urandom, 0, word);
    checkValue(testName, idcodeValue, word);

    testName = "irCapture";
    scanIr(instBypass, irOut);
    checkValue(testName, irCapturePattern, irOut);

    testName = "bypass";
    sent = $urandom & 32'h0000_FFFF;
    scanDr(16, sent, 0, word);
    checkValue(testName, {16'h0, sent[14:0], 1'b0}, word);

    testName = "unknownCode";
    scanIr(4'h3, irOut);
    checkValue(testName, irCapturePattern, irOut);
    sent = $urandom & 32'h0000_FFFF;
    scanDr(16, sent, 0, word);
    checkValue(testName, {16'h0, sent[14:0], 1'b0}, word);

    testName = "userCapture";
    scanIr(instUser, irOut);
    userWord     = $urandom;
    nextUserIn   = userWord;
    pulsesBefore = updateCount;
    sent         = $urandom;
    scanDr(32, sent, 0, word);
    checkValue(testName, userWord, word);
    checkValue("userUpdateWord", sent, userOut);
    checkValue("userUpdatePulses", 1, updateCount - pulsesBefore);

    testName   = "userPause";
    userWord   = $urandom;
    nextUserIn = userWord;
    sent       = $urandom;
    scanDr(32, sent, 16, word);
    checkValue(testName, userWord, word);
    checkValue("userPauseUpdate", sent, userOut);

    // Five TMS-high edges from the middle of a DR shift
    testName = "tmsReset";
    step(1'b1, 1'b0, b);
    step(1'b0, 1'b0, b);
    step(1'b0, 1'b0, b);
    for (i = 0; i < 10; i++) begin
      step(1'b0, 1'($urandom), b);
    end
    repeat (5) step(1'b1, 1'b0, b);
    step(1'b0, 1'b0, b);

    testName = "idcodeAgain";
    scanDr(32, $urandom, 0, word);
    checkValue(testName, idcodeValue, word);

    step(1'b0, 1'b0, b);
    step(1'b0, 1'b0, b);
    #2;
    $display("Simulation finished: PASS");
    $finish;
  end

endmodule

//--- compile.f
jtagTapPkg.sv
jtagInstrPkg.sv
tapController.sv
instructionRegister.sv
dataRegisters.sv
tdoOutputStage.sv
jtagTap.sv
tbJtagTap.sv
